//--- source/mem_front_pkg.sv
package mem_front_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    // Address and data word width, fixed by the bus format
    localparam int XLEN = 32;

    // One memory block per bus transfer
    localparam int BLOCK_BITS = 64;

    // Response and reply tags
    // Tag zero means no tag
    localparam int TAG_BITS = 4;

    // PC step between sequential instructions
    localparam int INST_BYTES = 4;

    ////////////////////
    // Address helpers
    ////////////////////

    // Byte offset bits inside one 64-bit block
    localparam int BLOCK_OFFSET_BITS = 3;

    // Address bit that picks the upper or lower word of a block
    localparam int WORD_SEL_BIT = 2;

    ////////////////////
    // Bus commands
    ////////////////////

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command;

endpackage

//--- source/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
    input  mem_front_pkg::bus_command               icache_command,
    input  logic [mem_front_pkg::XLEN-1:0]          icache_addr,
    input  mem_front_pkg::bus_command               dmem_command,
    input  logic [mem_front_pkg::XLEN-1:0]          dmem_addr,
    input  logic [mem_front_pkg::XLEN-1:0]          dmem_data,
    input  logic [mem_front_pkg::TAG_BITS-1:0]      mem2proc_response,
    output mem_front_pkg::bus_command               proc2mem_command,
    output logic [mem_front_pkg::XLEN-1:0]          proc2mem_addr,
    output logic [mem_front_pkg::BLOCK_BITS-1:0]    proc2mem_data,
    output logic [mem_front_pkg::TAG_BITS-1:0]      icache_response,
    output logic [mem_front_pkg::TAG_BITS-1:0]      dmem_response
);
    import mem_front_pkg::*;

    // Data port wins whenever it has a command
    always_comb begin
        if (dmem_command != BUS_NONE) begin
            proc2mem_command = dmem_command;
            proc2mem_addr    = dmem_addr;
            // Same-cycle acceptance goes to the data port only
            dmem_response    = mem2proc_response;
            icache_response  = '0;
        end else begin
            // Cache owns the bus, even when idle
            proc2mem_command = icache_command;
            proc2mem_addr    = icache_addr;
            dmem_response    = '0;
            // No tag back to an idle cache
            if (icache_command != BUS_NONE) begin
                icache_response = mem2proc_response;
            end else begin
                icache_response = '0;
            end
        end
    end

    // Store word rides in the low half of the block
    assign proc2mem_data = {{(BLOCK_BITS - XLEN){1'b0}}, dmem_data};

endmodule

//--- source/icache.sv
`timescale 1ns/100ps

module icache #(
    parameter int icache_lines = 16
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [mem_front_pkg::XLEN-1:0]          fetch_addr,
    input  logic                                    flush_miss,
    input  logic [mem_front_pkg::TAG_BITS-1:0]      icache_response,
    input  logic [mem_front_pkg::TAG_BITS-1:0]      mem2proc_tag,
    input  logic [mem_front_pkg::BLOCK_BITS-1:0]    mem2proc_data,
    output mem_front_pkg::bus_command               icache_command,
    output logic [mem_front_pkg::XLEN-1:0]          icache_addr,
    output logic [mem_front_pkg::BLOCK_BITS-1:0]    cache_block,
    output logic                                    cache_hit
);
    import mem_front_pkg::*;

    // Address split: tag | index | block offset
    localparam int index_bits    = $clog2(icache_lines);
    localparam int line_tag_bits = XLEN - BLOCK_OFFSET_BITS - index_bits;

    typedef enum logic [1:0] {
        idle,
        request,
        wait_reply
    } refill_state_t;

    ////////////////////
    // Line storage
    ////////////////////

    logic [icache_lines-1:0]   line_valid;
    logic [line_tag_bits-1:0]  line_tag [icache_lines];
    logic [BLOCK_BITS-1:0]     line_data [icache_lines];

    // Refill bookkeeping
    refill_state_t                      state;
    logic [XLEN-BLOCK_OFFSET_BITS-1:0]  miss_block;
    logic [TAG_BITS-1:0]                miss_tag;

    logic [index_bits-1:0]     fetch_index;
    logic [line_tag_bits-1:0]  fetch_tag;
    logic [index_bits-1:0]     fill_index;
    logic [line_tag_bits-1:0]  fill_tag;
    logic                      accepted;
    logic                      reply_match;

    assign fetch_index = fetch_addr[BLOCK_OFFSET_BITS +: index_bits];
    assign fetch_tag   = fetch_addr[XLEN-1 -: line_tag_bits];
    assign fill_index  = miss_block[index_bits-1:0];
    assign fill_tag    = miss_block[XLEN-BLOCK_OFFSET_BITS-1 -: line_tag_bits];

    // Lookup is combinational, so a hit returns its block this cycle
    assign cache_hit   = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_tag);
    assign cache_block = line_data[fetch_index];

    ////////////////////
    // Refill FSM
    ////////////////////

    // Load held until memory hands back a nonzero tag
    assign icache_command = (state == request) ? BUS_LOAD : BUS_NONE;
    assign icache_addr    = {miss_block, {BLOCK_OFFSET_BITS{1'b0}}};

    assign accepted    = (state == request) && (icache_response != '0);
    // Stored tag is never zero while waiting
    assign reply_match = (state == wait_reply) && (mem2proc_tag == miss_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= idle;
            line_valid <= '0;
        end else begin
            case (state)
                idle: begin
                    // A miss on a PC that is being abandoned starts nothing
                    if (!cache_hit && !flush_miss) begin
                        state <= request;
                    end
                end
                request: begin
                    // Acceptance beats a flush in the same cycle
                    if (accepted) begin
                        state <= wait_reply;
                    end else if (flush_miss) begin
                        state <= idle;
                    end
                end
                wait_reply: begin
                    // Accepted loads always fill, even after a branch
                    if (reply_match) begin
                        line_valid[fill_index] <= 1'b1;
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Miss address tracks the PC until the FSM leaves idle
    always_ff @(posedge clock) begin
        if (state == idle) begin
            miss_block <= fetch_addr[XLEN-1:BLOCK_OFFSET_BITS];
        end
        if (accepted) begin
            miss_tag <= icache_response;
        end
        if (reply_match) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= mem2proc_data;
        end
    end

endmodule

//--- source/ifetch.sv
`timescale 1ns/100ps

module ifetch (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [mem_front_pkg::XLEN-1:0]          reset_pc,
    input  logic                                    fetch_enable,
    input  logic                                    branch_taken,
    input  logic [mem_front_pkg::XLEN-1:0]          branch_target,
    input  logic [mem_front_pkg::BLOCK_BITS-1:0]    cache_block,
    input  logic                                    cache_hit,
    output logic [mem_front_pkg::XLEN-1:0]          fetch_addr,
    output logic                                    flush_miss,
    output logic                                    fetch_valid,
    output logic [mem_front_pkg::XLEN-1:0]          fetch_pc,
    output logic [mem_front_pkg::XLEN-1:0]          fetch_inst
);
    import mem_front_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_seq_pc;

    ////////////////////
    // Cache lookup
    ////////////////////

    // Current PC goes to the cache every cycle
    assign fetch_addr = pc;

    // Abandon a refill that has not been accepted yet
    assign flush_miss = branch_taken;

    // One instruction per enabled hit, none in a branch cycle
    assign fetch_valid = fetch_enable && cache_hit && !branch_taken;
    assign fetch_pc    = pc;

    // Upper or lower word of the block by PC bit 2
    always_comb begin
        if (pc[WORD_SEL_BIT]) begin
            fetch_inst = cache_block[BLOCK_BITS-1 -: XLEN];
        end else begin
            fetch_inst = cache_block[XLEN-1:0];
        end
    end

    ////////////////////
    // PC sequencing
    ////////////////////

    assign next_seq_pc = pc + INST_BYTES;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (branch_taken) begin
            // Redirect wins over sequential advance
            pc <= branch_target;
        end else if (fetch_valid) begin
            pc <= next_seq_pc;
        end
        // Miss or disabled fetch holds the PC
    end

endmodule

//--- source/dmem_port.sv
`timescale 1ns/100ps

module dmem_port (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    dmem_request,
    input  logic                                    dmem_write,
    input  logic [mem_front_pkg::XLEN-1:0]          dmem_addr,
    input  logic [mem_front_pkg::XLEN-1:0]          dmem_wdata,
    input  logic [mem_front_pkg::TAG_BITS-1:0]      dmem_response,
    input  logic [mem_front_pkg::TAG_BITS-1:0]      mem2proc_tag,
    input  logic [mem_front_pkg::BLOCK_BITS-1:0]    mem2proc_data,
    output mem_front_pkg::bus_command               dmem_command,
    output logic [mem_front_pkg::XLEN-1:0]          bus_addr,
    output logic [mem_front_pkg::XLEN-1:0]          bus_data,
    output logic                                    dmem_busy,
    output logic                                    dmem_done,
    output logic [mem_front_pkg::XLEN-1:0]          dmem_rdata
);
    import mem_front_pkg::*;

    typedef enum logic [1:0] {
        idle,
        request,
        wait_reply
    } access_state_t;

    access_state_t        state;
    logic                 done_q;
    logic                 write_q;
    logic [XLEN-1:0]      addr_q;
    logic [XLEN-1:0]      data_q;
    logic [TAG_BITS-1:0]  tag_q;

    logic                 start;
    logic                 accepted;
    logic                 reply_match;
    logic [XLEN-1:0]      reply_word;

    // New access only when fully idle, done cycle included
    assign start       = (state == idle) && !done_q && dmem_request;
    assign accepted    = (state == request) && (dmem_response != '0);
    assign reply_match = (state == wait_reply) && (mem2proc_tag == tag_q);
    assign reply_word  = addr_q[WORD_SEL_BIT] ? mem2proc_data[BLOCK_BITS-1 -: XLEN]
                                              : mem2proc_data[XLEN-1:0];

    ////////////////////
    // Bus side
    ////////////////////

    assign dmem_command = (state != request) ? BUS_NONE :
                          write_q            ? BUS_STORE : BUS_LOAD;
    assign bus_addr     = addr_q;
    assign bus_data     = data_q;

    // Busy spans request, wait and the done cycle
    assign dmem_busy = (state != idle) || done_q;
    assign dmem_done = done_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= idle;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                idle: if (start) state <= request;
                request: begin
                    if (accepted) begin
                        // Stores finish at acceptance
                        if (write_q) begin
                            state  <= idle;
                            done_q <= 1'b1;
                        end else begin
                            state <= wait_reply;
                        end
                    end
                end
                wait_reply: begin
                    if (reply_match) begin
                        state  <= idle;
                        done_q <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Request fields, load tag and returned word
    always_ff @(posedge clock) begin
        if (start) begin
            write_q <= dmem_write;
            addr_q  <= dmem_addr;
            data_q  <= dmem_wdata;
        end
        if (accepted) tag_q <= dmem_response;
        if (reply_match) dmem_rdata <= reply_word;
    end

endmodule

//--- source/mem_front.sv
`timescale 1ns/100ps

module mem_front #(
    parameter int icache_lines = 16
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [mem_front_pkg::XLEN-1:0]          reset_pc,
    input  logic                                    fetch_enable,
    input  logic                                    branch_taken,
    input  logic [mem_front_pkg::XLEN-1:0]          branch_target,
    input  logic                                    dmem_request,
    input  logic                                    dmem_write,
    input  logic [mem_front_pkg::XLEN-1:0]          dmem_addr,
    input  logic [mem_front_pkg::XLEN-1:0]          dmem_wdata,
    input  logic [mem_front_pkg::TAG_BITS-1:0]      mem2proc_response,
    input  logic [mem_front_pkg::BLOCK_BITS-1:0]    mem2proc_data,
    input  logic [mem_front_pkg::TAG_BITS-1:0]      mem2proc_tag,
    output mem_front_pkg::bus_command               proc2mem_command,
    output logic [mem_front_pkg::XLEN-1:0]          proc2mem_addr,
    output logic [mem_front_pkg::BLOCK_BITS-1:0]    proc2mem_data,
    output logic                                    fetch_valid,
    output logic [mem_front_pkg::XLEN-1:0]          fetch_pc,
    output logic [mem_front_pkg::XLEN-1:0]          fetch_inst,
    output logic                                    dmem_busy,
    output logic                                    dmem_done,
    output logic [mem_front_pkg::XLEN-1:0]          dmem_rdata
);
    import mem_front_pkg::*;

    ////////////////////
    // Fetch to cache
    ////////////////////

    logic [XLEN-1:0]        fetch_addr;
    logic                   flush_miss;
    logic [BLOCK_BITS-1:0]  cache_block;
    logic                   cache_hit;

    // Requesters to arbiter
    bus_command             icache_command;
    logic [XLEN-1:0]        icache_addr;
    logic [TAG_BITS-1:0]    icache_response;
    bus_command             dmem_command;
    logic [XLEN-1:0]        dmem_bus_addr;
    logic [XLEN-1:0]        dmem_bus_data;
    logic [TAG_BITS-1:0]    dmem_response;

    ifetch ifetch_0 (
        .clock(clock),
        .reset(reset),
        .reset_pc(reset_pc),
        .fetch_enable(fetch_enable),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .cache_block(cache_block),
        .cache_hit(cache_hit),
        .fetch_addr(fetch_addr),
        .flush_miss(flush_miss),
        .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst)
    );

    // Reply tags go to both cache and data port
    icache #(
        .icache_lines(icache_lines)
    ) icache_0 (
        .clock(clock),
        .reset(reset),
        .fetch_addr(fetch_addr),
        .flush_miss(flush_miss),
        .icache_response(icache_response),
        .mem2proc_tag(mem2proc_tag),
        .mem2proc_data(mem2proc_data),
        .icache_command(icache_command),
        .icache_addr(icache_addr),
        .cache_block(cache_block),
        .cache_hit(cache_hit)
    );

    dmem_port dmem_port_0 (
        .clock(clock),
        .reset(reset),
        .dmem_request(dmem_request),
        .dmem_write(dmem_write),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_response(dmem_response),
        .mem2proc_tag(mem2proc_tag),
        .mem2proc_data(mem2proc_data),
        .dmem_command(dmem_command),
        .bus_addr(dmem_bus_addr),
        .bus_data(dmem_bus_data),
        .dmem_busy(dmem_busy),
        .dmem_done(dmem_done),
        .dmem_rdata(dmem_rdata)
    );

    // Data port has priority on the shared bus
    mem_arbiter mem_arbiter_0 (
        .icache_command(icache_command),
        .icache_addr(icache_addr),
        .dmem_command(dmem_command),
        .dmem_addr(dmem_bus_addr),
        .dmem_data(dmem_bus_data),
        .mem2proc_response(mem2proc_response),
        .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr),
        .proc2mem_data(proc2mem_data),
        .icache_response(icache_response),
        .dmem_response(dmem_response)
    );

endmodule

//--- bench/mem_front_props.sv
`timescale 1ns/100ps

module mem_front_props (
    input  logic                        clock,
    input  logic                        reset,
    input  mem_front_pkg::bus_command   proc2mem_command,
    input  logic                        fetch_valid,
    input  logic                        branch_taken,
    input  logic                        dmem_request,
    input  logic                        dmem_done,
    input  logic                        dmem_busy
);
    import mem_front_pkg::*;

    ////////////////////
    // Reset behavior
    ////////////////////

    // Bus idle once reset has been seen for a full cycle
    bus_idle_in_reset: assert property (@(posedge clock)
        reset && $past(reset) |-> proc2mem_command == BUS_NONE)
        else $error("bus command during reset");

    ////////////////////
    // Fetch and data
    ////////////////////

    // Redirect cycle never delivers an instruction
    no_fetch_on_branch: assert property (@(posedge clock) disable iff (reset)
        branch_taken |-> !fetch_valid)
        else $error("fetch_valid in branch cycle");

    // Idle port with no request stays quiet next cycle
    no_done_from_idle: assert property (@(posedge clock) disable iff (reset)
        !dmem_busy && !dmem_request |=> !dmem_done)
        else $error("dmem_done without a request");

endmodule

bind mem_front mem_front_props props_0 (
    .clock(clock),
    .reset(reset),
    .proc2mem_command(proc2mem_command),
    .fetch_valid(fetch_valid),
    .branch_taken(branch_taken),
    .dmem_request(dmem_request),
    .dmem_done(dmem_done),
    .dmem_busy(dmem_busy)
);

//--- bench/mem_front_tb.sv
`timescale 1ns/100ps

module mem_front_tb;
    import mem_front_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int HALF_BYTES  = 512;
    localparam int RESET_PC    = 32'h40;
    localparam int FETCH_GOAL  = 400;
    localparam int DATA_GOAL   = 60;
    localparam int MAX_CYCLES  = 20000;
    localparam int STALL_LIMIT = 300;

    logic                   clock;
    logic                   reset;
    logic [XLEN-1:0]        reset_pc;
    logic                   fetch_enable;
    logic                   branch_taken;
    logic [XLEN-1:0]        branch_target;
    logic                   dmem_request;
    logic                   dmem_write;
    logic [XLEN-1:0]        dmem_addr;
    logic [XLEN-1:0]        dmem_wdata;
    logic [TAG_BITS-1:0]    mem2proc_response;
    logic [BLOCK_BITS-1:0]  mem2proc_data;
    logic [TAG_BITS-1:0]    mem2proc_tag;
    bus_command             proc2mem_command;
    logic [XLEN-1:0]        proc2mem_addr;
    logic [BLOCK_BITS-1:0]  proc2mem_data;
    logic                   fetch_valid;
    logic [XLEN-1:0]        fetch_pc;
    logic [XLEN-1:0]        fetch_inst;
    logic                   dmem_busy;
    logic                   dmem_done;
    logic [XLEN-1:0]        dmem_rdata;

    ////////////////////
    // Reference state
    ////////////////////

    integer           seed;
    logic [XLEN-1:0]  mem [MEM_WORDS];
    int               cycle;
    logic [XLEN-1:0]  model_pc;
    int               fetch_count;
    int               data_count;
    int               fetch_stall;
    int               data_stall;
    // Data access in flight, and not yet accepted by memory
    bit               data_active;
    bit               data_waiting;
    bit               data_is_write;
    logic [XLEN-1:0]  data_addr;
    logic [XLEN-1:0]  data_wdata;
    logic [TAG_BITS-1:0] next_tag;

    // Pending load replies, oldest first
    logic [TAG_BITS-1:0] q_tag [$];
    logic [XLEN-1:0]     q_addr [$];
    int                  q_due [$];
    bit                  q_inst [$];

    // Expected cache contents, block address per line
    logic [XLEN-1:0]  line_block [64];
    bit               line_valid [64];
    int               lines;

    mem_front #(
        .icache_lines(16)
    ) uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic int rand_below(int unsigned n);
        int unsigned u;
        u = $random(seed);
        return int'(u % n);
    endfunction

    function automatic logic [XLEN-1:0] word_at(logic [XLEN-1:0] addr);
        return mem[addr[9:2]];
    endfunction

    // Block of two words, upper word at the odd word address
    function automatic logic [BLOCK_BITS-1:0] block_at(logic [XLEN-1:0] addr);
        return {mem[{addr[9:3], 1'b1}], mem[{addr[9:3], 1'b0}]};
    endfunction

    task automatic report_mismatch(string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic report_timeout(string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    endtask

    ////////////////////
    // Per-cycle drive
    ////////////////////

    task automatic drive_inputs();
        int idx;
        branch_taken = 1'b0;
        dmem_request = 1'b0;
        fetch_enable = rand_below(8) != 0;
        // Forced branch keeps the PC inside the code half
        if (model_pc >= HALF_BYTES - 8 || rand_below(16) == 0) begin
            branch_taken = 1'b1;
            if (rand_below(2) != 0) begin
                // Small loop region that fits in the cache
                branch_target = RESET_PC + 4 * rand_below(24);
            end else begin
                branch_target = 4 * rand_below(HALF_BYTES / 4 - 2);
            end
        end
        if (!data_active && rand_below(4) == 0) begin
            dmem_request  = 1'b1;
            dmem_write    = rand_below(2) != 0;
            dmem_addr     = HALF_BYTES + 4 * rand_below(128);
            dmem_wdata    = $random(seed);
            data_active   = 1'b1;
            data_is_write = dmem_write;
            data_addr     = dmem_addr;
            data_wdata    = dmem_wdata;
        end
        // At most one reply per cycle
        mem2proc_tag  = '0;
        mem2proc_data = '0;
        if (q_tag.size() > 0 && q_due[0] <= cycle) begin
            mem2proc_tag  = q_tag[0];
            mem2proc_data = block_at(q_addr[0]);
            if (q_inst[0]) begin
                idx = int'((q_addr[0] >> 3) % lines);
                line_valid[idx] = 1'b1;
                line_block[idx] = q_addr[0] >> 3;
            end
            void'(q_tag.pop_front());
            void'(q_addr.pop_front());
            void'(q_due.pop_front());
            void'(q_inst.pop_front());
        end
        // Refuse about one command in four
        if (proc2mem_command != BUS_NONE && rand_below(4) != 0) begin
            mem2proc_response = next_tag;
        end else begin
            mem2proc_response = '0;
        end
    endtask

    ////////////////////
    // Per-cycle checks
    ////////////////////

    task automatic check_cycle();
        int idx;
        fetch_stall++;
        if (branch_taken) begin
            assert (!fetch_valid) else report_mismatch("fetch_valid in branch cycle");
            model_pc = branch_target;
        end else if (fetch_valid) begin
            assert (fetch_enable) else report_mismatch("fetch_valid while fetch disabled");
            assert (fetch_pc == model_pc) else report_mismatch("fetch_pc differs from model PC");
            assert (fetch_inst == word_at(model_pc)) else report_mismatch("fetch_inst wrong");
            model_pc = model_pc + INST_BYTES;
            fetch_count++;
            fetch_stall = 0;
        end
        if (fetch_stall > STALL_LIMIT) report_timeout("no instruction fetched for too long");

        // Waiting data access owns the bus
        if (data_waiting) begin
            assert (proc2mem_command == (data_is_write ? BUS_STORE : BUS_LOAD)
                    && proc2mem_addr == data_addr)
                else report_mismatch("bus not given to waiting data access");
        end

        // Cache loads, refused ones included
        if (proc2mem_command == BUS_LOAD && !data_waiting) begin
            assert (proc2mem_addr < HALF_BYTES) else report_mismatch("fetch outside code");
            idx = int'((proc2mem_addr >> 3) % lines);
            assert (!(line_valid[idx] && line_block[idx] == (proc2mem_addr >> 3)))
                else report_mismatch("refill of a line already filled");
        end

        if (proc2mem_command != BUS_NONE && mem2proc_response != '0) begin
            if (proc2mem_command == BUS_STORE) begin
                assert (data_waiting && data_is_write) else report_mismatch("unexpected store");
                assert (proc2mem_data[XLEN-1:0] == data_wdata)
                    else report_mismatch("store data wrong");
                mem[proc2mem_addr[9:2]] = proc2mem_data[XLEN-1:0];
                data_waiting = 1'b0;
            end else begin
                q_tag.push_back(mem2proc_response);
                q_addr.push_back(proc2mem_addr);
                q_due.push_back(cycle + 1 + rand_below(6));
                if (data_waiting) begin
                    q_inst.push_back(1'b0);
                    data_waiting = 1'b0;
                end else begin
                    q_inst.push_back(1'b1);
                end
            end
            next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
        end

        // Busy from the cycle after the request through the done cycle
        assert (dmem_busy == (data_active && !dmem_request))
            else report_mismatch("dmem_busy wrong");

        if (dmem_done) begin
            assert (data_active) else report_mismatch("dmem_done without a request");
            if (!data_is_write) begin
                assert (dmem_rdata == word_at(data_addr)) else report_mismatch("load data wrong");
            end
            data_active = 1'b0;
            data_count++;
            data_stall = 0;
        end
        if (data_active) begin
            data_stall++;
            if (data_stall > STALL_LIMIT) report_timeout("data access did not complete");
        end
        // Command shows up from the next cycle on
        if (dmem_request) data_waiting = 1'b1;
    endtask

    initial begin
        seed              = 32;
        reset             = 1'b1;
        reset_pc          = RESET_PC;
        fetch_enable      = 1'b0;
        branch_taken      = 1'b0;
        branch_target     = '0;
        dmem_request      = 1'b0;
        dmem_write        = 1'b0;
        dmem_addr         = '0;
        dmem_wdata        = '0;
        mem2proc_response = '0;
        mem2proc_data     = '0;
        mem2proc_tag      = '0;
        cycle             = 0;
        model_pc          = RESET_PC;
        fetch_count       = 0;
        data_count        = 0;
        fetch_stall       = 0;
        data_stall        = 0;
        data_active       = 1'b0;
        data_waiting      = 1'b0;
        data_is_write     = 1'b0;
        data_addr         = '0;
        data_wdata        = '0;
        next_tag          = 4'h1;
        lines             = uut.icache_lines;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = $random(seed);
        for (int i = 0; i < 64; i++) line_valid[i] = 1'b0;

        repeat (16) @(posedge clock);
        #1 reset = 1'b0;

        // Bounded run until both streams reach their goals
        while ((fetch_count < FETCH_GOAL || data_count < DATA_GOAL) && cycle < MAX_CYCLES) begin
            @(posedge clock);
            cycle++;
            #1;
            drive_inputs();
            @(negedge clock);
            check_cycle();
        end

        if (fetch_count >= FETCH_GOAL && data_count >= DATA_GOAL) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_timeout("run ended before all accesses completed");
        end
    end

endmodule

//--- vlog.f
source/mem_front_pkg.sv
source/mem_arbiter.sv
source/icache.sv
source/ifetch.sv
source/dmem_port.sv
source/mem_front.sv
bench/mem_front_props.sv
bench/mem_front_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module mem_front_tb \
    -Mdir obj_dir \
    -o mem_front_sim \
    && ./obj_dir/mem_front_sim \
    || { echo "simulation failed"; exit 1; }

exit 0
